// File: project.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/reservation_station.sv
hdl/alu.sv
hdl/alu_fu.sv
hdl/result_broadcast.sv
hdl/ooo_alu_slice.sv
bench/ooo_alu_slice_checker.sv
bench/ooo_alu_slice_tb.sv

// File: bench/ooo_alu_slice_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module ooo_alu_slice_tb;
	import ooo_pkg::*;

	localparam int N_ROWS      = 31;
	localparam int WAIT_LIMIT  = 200;
	localparam int SEED        = 40492;
	localparam int BURST_FIRST = 21;
	localparam int BURST_LAST  = 26;

	typedef enum logic [1:0] {IDLE, PENDING, DONE, DROPPED} row_state_e;

	// dep1 and dep2 name the producing row, -1 when the value is given
	typedef struct {
		logic [`TAG_W-1:0]  tag;
		alu_func_e          func;
		opa_select_e        opa_sel;
		opb_select_e        opb_sel;
		logic [`XLEN-1:0]   pc;
		logic [`INST_W-1:0] inst;
		logic [`XLEN-1:0]   val1;
		int                 dep1;
		logic [`XLEN-1:0]   val2;
		int                 dep2;
		bit                 burst;
		bit                 drain;
		bit                 flush_after;
		logic [`XLEN-1:0]   expected;
	} row_t;

	row_t             rows      [N_ROWS];
	row_state_e       state     [N_ROWS];
	logic [`XLEN-1:0] bus_value [N_ROWS];

	logic               clock;
	logic               reset;
	logic               flush;
	logic               dispatch_valid;
	logic [`TAG_W-1:0]  dispatch_tag;
	alu_func_e          dispatch_func;
	opa_select_e        dispatch_opa_sel;
	opb_select_e        dispatch_opb_sel;
	logic [`XLEN-1:0]   dispatch_pc;
	logic [`INST_W-1:0] dispatch_inst;
	logic [`XLEN-1:0]   src1_value;
	logic               src1_ready;
	logic [`TAG_W-1:0]  src1_tag;
	logic [`XLEN-1:0]   src2_value;
	logic               src2_ready;
	logic [`TAG_W-1:0]  src2_tag;
	logic               dispatch_ready;
	logic               cdb_valid;
	logic [`TAG_W-1:0]  cdb_tag;
	logic [`XLEN-1:0]   cdb_value;

	int checks;
	int value_errors;
	int other_errors;
	int assertion_failures;
	bit timed_out;
	bit saw_back_pressure;

	ooo_alu_slice i_dut (
		.clock            (clock),
		.reset            (reset),
		.flush            (flush),
		.dispatch_valid   (dispatch_valid),
		.dispatch_tag     (dispatch_tag),
		.dispatch_func    (dispatch_func),
		.dispatch_opa_sel (dispatch_opa_sel),
		.dispatch_opb_sel (dispatch_opb_sel),
		.dispatch_pc      (dispatch_pc),
		.dispatch_inst    (dispatch_inst),
		.src1_value       (src1_value),
		.src1_ready       (src1_ready),
		.src1_tag         (src1_tag),
		.src2_value       (src2_value),
		.src2_ready       (src2_ready),
		.src2_tag         (src2_tag),
		.dispatch_ready   (dispatch_ready),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_value        (cdb_value)
	);

	// internal handshakes of the slice
	bind ooo_alu_slice ooo_alu_slice_checker i_checker (
		.clock           (clock),
		.reset           (reset),
		.flush           (flush),
		.dispatch_valid  (dispatch_valid),
		.dispatch_ready  (dispatch_ready),
		.issue_valid     (issue_valid),
		.fu_busy         (fu_busy),
		.fu_result_valid (fu_result_valid),
		.cdb_valid       (cdb_valid)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// RV32I integer semantics
	function automatic logic [`XLEN-1:0] alu_model(alu_func_e f, logic [`XLEN-1:0] a,
			logic [`XLEN-1:0] b);
		int         sa;
		int         sb;
		logic [4:0] sh;
		sa = a;
		sb = b;
		sh = b[4:0];
		case (f)
			ADD:     return a + b;
			SUB:     return a - b;
			SLT:     return (sa < sb) ? 1 : 0;
			SLTU:    return (a < b) ? 1 : 0;
			AND:     return a & b;
			OR:      return a | b;
			XOR:     return a ^ b;
			SLL:     return a << sh;
			SRL:     return a >> sh;
			SRA:     return `XLEN'(sa >>> sh);
			default: return 'x;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] opa_model(opa_select_e s, logic [`XLEN-1:0] rs1,
			logic [`XLEN-1:0] pc);
		case (s)
			OPA_IS_RS1: return rs1;
			OPA_IS_PC:  return pc;
			default:    return '0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] opb_model(opb_select_e s, logic [`XLEN-1:0] rs2,
			logic [`INST_W-1:0] inst);
		case (s)
			OPB_IS_I_IMM: return `XLEN'($signed(inst[31:20]));
			OPB_IS_U_IMM: return `XLEN'($signed({inst[31:12], 12'h000}));
			default:      return rs2;
		endcase
	endfunction

	function automatic void reg_row(int r, int tag, alu_func_e f, logic [`XLEN-1:0] v1,
			int d1, logic [`XLEN-1:0] v2, int d2);
		rows[r].tag         = `TAG_W'(tag);
		rows[r].func        = f;
		rows[r].opa_sel     = OPA_IS_RS1;
		rows[r].opb_sel     = OPB_IS_RS2;
		rows[r].pc          = '0;
		rows[r].inst        = '0;
		rows[r].val1        = v1;
		rows[r].dep1        = d1;
		rows[r].val2        = v2;
		rows[r].dep2        = d2;
		rows[r].burst       = 1'b0;
		rows[r].drain       = 1'b0;
		rows[r].flush_after = 1'b0;
		rows[r].expected    = '0;
	endfunction

	function automatic void imm_row(int r, int tag, alu_func_e f, opa_select_e a,
			opb_select_e b, logic [`XLEN-1:0] pc, logic [`INST_W-1:0] inst,
			logic [`XLEN-1:0] v1);
		reg_row(r, tag, f, v1, -1, '0, -1);
		rows[r].opa_sel = a;
		rows[r].opb_sel = b;
		rows[r].pc      = pc;
		rows[r].inst    = inst;
	endfunction

	function automatic void build_table();
		// every function with register operands
		reg_row(0, 0, ADD, 32'h0000_0007, -1, 32'hffff_fffd, -1);
		reg_row(1, 1, SUB, 32'h0000_0005, -1, 32'h0000_0009, -1);
		reg_row(2, 2, SLT, 32'hffff_fff0, -1, 32'h0000_0001, -1);
		reg_row(3, 3, SLTU, 32'hffff_fff0, -1, 32'h0000_0001, -1);
		reg_row(4, 4, AND, 32'hf0f0_1234, -1, 32'h0ff0_ff00, -1);
		reg_row(5, 5, OR, 32'h1200_0034, -1, 32'h0034_5600, -1);
		reg_row(6, 6, XOR, 32'haaaa_5555, -1, 32'hffff_0000, -1);
		reg_row(7, 7, SLL, 32'h0000_0001, -1, 32'h0000_0023, -1);
		reg_row(8, 8, SRL, 32'h8000_0000, -1, 32'h0000_0004, -1);
		reg_row(9, 9, SRA, 32'h8000_0000, -1, 32'h0000_0004, -1);
		reg_row(10, 10, SLT, 32'h0000_0005, -1, 32'hffff_ffff, -1);
		reg_row(11, 11, SLTU, 32'h0000_0005, -1, 32'hffff_ffff, -1);
		// operand selects and immediates
		imm_row(12, 12, ADD, OPA_IS_PC, OPB_IS_I_IMM, 32'h1000, 32'hffc0_0013, '0);
		imm_row(13, 13, ADD, OPA_IS_ZERO, OPB_IS_U_IMM, '0, 32'h1234_5037, '0);
		imm_row(14, 14, ADD, OPA_IS_PC, OPB_IS_U_IMM, 32'h2000, 32'h8000_0017, '0);
		imm_row(15, 15, OR, OPA_IS_RS1, OPB_IS_I_IMM, '0, 32'h70f0_6013, 32'h0f0);
		// dependency chain, row 20 may finish ahead of it
		reg_row(16, 1, ADD, 32'd10, -1, 32'd20, -1);
		reg_row(17, 2, SUB, '0, 16, 32'd4, -1);
		reg_row(18, 3, SLL, 32'd3, -1, '0, 17);
		reg_row(19, 4, XOR, '0, 18, '0, 16);
		reg_row(20, 5, ADD, 32'd1, -1, 32'd1, -1);
		// producer followed by five waiting rows, fills the station
		reg_row(21, 6, ADD, 32'd100, -1, 32'd23, -1);
		reg_row(22, 7, ADD, '0, 21, 32'd1, -1);
		reg_row(23, 8, SUB, '0, 21, 32'd3, -1);
		reg_row(24, 9, SLL, '0, 21, 32'd2, -1);
		reg_row(25, 10, XOR, '0, 21, 32'h0ff, -1);
		reg_row(26, 11, SLTU, '0, 21, 32'd200, -1);
		// two rows waiting on each other, dropped by the flush
		reg_row(27, 12, ADD, '0, 28, 32'd1, -1);
		reg_row(28, 13, AND, '0, 27, '0, 27);
		reg_row(29, 12, SRA, 32'hf000_0000, -1, 32'd8, -1);
		reg_row(30, 13, SUB, '0, 29, 32'h10, -1);
		rows[16].drain       = 1'b1;
		rows[BURST_FIRST].drain = 1'b1;
		rows[27].drain       = 1'b1;
		rows[28].flush_after = 1'b1;
		for (int r = BURST_FIRST + 1; r <= BURST_LAST; r++) begin
			rows[r].burst = 1'b1;
		end
	endfunction

	function automatic void compute_expected();
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		for (int r = 0; r < N_ROWS; r++) begin
			a = rows[r].val1;
			b = rows[r].val2;
			if (rows[r].dep1 >= 0 && rows[r].dep1 < r) begin
				a = rows[rows[r].dep1].expected;
			end
			if (rows[r].dep2 >= 0 && rows[r].dep2 < r) begin
				b = rows[rows[r].dep2].expected;
			end
			rows[r].expected = alu_model(rows[r].func,
				opa_model(rows[r].opa_sel, a, rows[r].pc),
				opb_model(rows[r].opb_sel, b, rows[r].inst));
			state[r] = IDLE;
		end
	endfunction

	task automatic dispatch_row(input int r);
		int waited;
		int d1;
		int d2;
		waited = 0;
		d1     = rows[r].dep1;
		d2     = rows[r].dep2;
		while (dispatch_ready !== 1'b1 && waited < WAIT_LIMIT) begin
			saw_back_pressure = 1'b1;
			@(posedge clock);
			#2;
			waited++;
		end
		if (dispatch_ready !== 1'b1) begin
			timed_out = 1'b1;
			other_errors++;
			$display("dispatch_ready stayed low, row %0d could not be dispatched", r);
		end else begin
			dispatch_valid   = 1'b1;
			dispatch_tag     = rows[r].tag;
			dispatch_func    = rows[r].func;
			dispatch_opa_sel = rows[r].opa_sel;
			dispatch_opb_sel = rows[r].opb_sel;
			dispatch_pc      = rows[r].pc;
			dispatch_inst    = rows[r].inst;
			// a finished producer is read like a register file
			if (d1 < 0) begin
				src1_ready = 1'b1;
				src1_value = rows[r].val1;
				src1_tag   = '0;
			end else begin
				src1_ready = (state[d1] == DONE);
				src1_value = src1_ready ? bus_value[d1] : '0;
				src1_tag   = rows[d1].tag;
			end
			if (d2 < 0) begin
				src2_ready = 1'b1;
				src2_value = rows[r].val2;
				src2_tag   = '0;
			end else begin
				src2_ready = (state[d2] == DONE);
				src2_value = src2_ready ? bus_value[d2] : '0;
				src2_tag   = rows[d2].tag;
			end
			state[r] = PENDING;
			@(posedge clock);
			#2;
			dispatch_valid = 1'b0;
		end
	endtask

	task automatic wait_all_done(input int upto);
		int waited;
		bit open;
		waited = 0;
		open   = 1'b1;
		while (open && waited < WAIT_LIMIT) begin
			open = 1'b0;
			for (int r = 0; r < upto; r++) begin
				if (state[r] == PENDING) begin
					open = 1'b1;
				end
			end
			if (open) begin
				@(posedge clock);
				#2;
				waited++;
			end
		end
		if (open) begin
			timed_out = 1'b1;
			for (int r = 0; r < upto; r++) begin
				if (state[r] == PENDING) begin
					other_errors++;
					$display("row %0d with tag %0d never produced a result", r, rows[r].tag);
				end
			end
		end
	endtask

	task automatic apply_flush();
		flush = 1'b1;
		@(posedge clock);
		#2;
		// the bus pulse seen at the flush edge was already on its way
		for (int r = 0; r < N_ROWS; r++) begin
			if (state[r] == PENDING) begin
				state[r] = DROPPED;
			end
		end
		flush = 1'b0;
	endtask

	// scoreboard on the common data bus
	always @(posedge clock) begin : bus_monitor
		int hit;
		if (!reset && cdb_valid === 1'b1) begin
			hit = -1;
			for (int r = 0; r < N_ROWS; r++) begin
				if (state[r] == PENDING && rows[r].tag == cdb_tag) begin
					hit = r;
				end
			end
			checks++;
			assert (hit >= 0) else begin
				other_errors++;
				$display("bus carried tag %0d at %0t with no row waiting for it", cdb_tag, $time);
			end
			if (hit >= 0) begin
				assert (cdb_value === rows[hit].expected) else begin
					value_errors++;
					$display("ERROR %0t: tag %0d result %h, expected %h", $time, cdb_tag,
						cdb_value, rows[hit].expected);
				end
				bus_value[hit] = cdb_value;
				state[hit]     = DONE;
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		reset             = 1'b1;
		flush             = 1'b0;
		dispatch_valid    = 1'b0;
		dispatch_tag      = '0;
		dispatch_func     = ADD;
		dispatch_opa_sel  = OPA_IS_RS1;
		dispatch_opb_sel  = OPB_IS_RS2;
		dispatch_pc       = '0;
		dispatch_inst     = '0;
		src1_value        = '0;
		src1_ready        = 1'b0;
		src1_tag          = '0;
		src2_value        = '0;
		src2_ready        = 1'b0;
		src2_tag          = '0;
		checks            = 0;
		value_errors      = 0;
		other_errors      = 0;
		timed_out         = 1'b0;
		saw_back_pressure = 1'b0;
		build_table();
		compute_expected();

		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		checks++;
		assert (dispatch_ready === 1'b1 && cdb_valid === 1'b0) else begin
			other_errors++;
			$display("after reset the station is not ready or the bus is not idle");
		end

		for (int r = 0; r < N_ROWS && !timed_out; r++) begin
			if (rows[r].drain) begin
				wait_all_done(r);
			end
			if (r == BURST_FIRST) begin
				saw_back_pressure = 1'b0;
			end
			if (r == BURST_LAST + 1) begin
				checks++;
				assert (saw_back_pressure) else begin
					other_errors++;
					$display("dispatch_ready never dropped while the burst filled the station");
				end
			end
			if (!rows[r].burst) begin
				repeat ($urandom % 4) begin
					@(posedge clock);
					#2;
				end
			end
			if (!timed_out) begin
				dispatch_row(r);
			end
			if (rows[r].flush_after && !timed_out) begin
				apply_flush();
			end
		end
		if (!timed_out) begin
			wait_all_done(N_ROWS);
		end
		// give dropped tags time to show up if they were not dropped
		repeat (8) @(posedge clock);

		assertion_failures = i_dut.i_checker.failures;
		$display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
			checks, value_errors, other_errors, assertion_failures);
		if (value_errors == 0 && other_errors == 0 && assertion_failures == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/ooo_alu_slice_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_alu_slice_checker (
	input logic clock,
	input logic reset,
	input logic flush,
	input logic dispatch_valid,
	input logic dispatch_ready,
	input logic issue_valid,
	input logic fu_busy,
	input logic fu_result_valid,
	input logic cdb_valid
);

	// read by the testbench at the end of the run
	int failures = 0;

	dispatch_into_free_entry: assert property (@(posedge clock) disable iff (reset)
		dispatch_valid |-> dispatch_ready)
		else begin
			failures++;
			$error("dispatch while the station has no free entry");
		end

	// a flush in the same cycle drops the broadcast
	bus_follows_result: assert property (@(posedge clock) disable iff (reset)
		fu_result_valid && !flush |=> cdb_valid)
		else begin
			failures++;
			$error("result not broadcast one cycle after fu_result_valid");
		end

	bus_has_result: assert property (@(posedge clock) disable iff (reset)
		cdb_valid |-> $past(fu_result_valid))
		else begin
			failures++;
			$error("cdb_valid without a unit result in the cycle before");
		end

	// an issue keeps the unit busy, and the station quiet, for the next cycle
	no_issue_while_busy: assert property (@(posedge clock) disable iff (reset)
		issue_valid && !flush |=> fu_busy && !issue_valid)
		else begin
			failures++;
			$error("unit not busy after an issue, or issue while the unit is busy");
		end

	strobes_quiet_in_reset: assert property (@(posedge clock)
		reset |-> !dispatch_valid ##1 !issue_valid && !fu_busy && !fu_result_valid && !cdb_valid)
		else begin
			failures++;
			$error("strobe active during reset");
		end

endmodule

`default_nettype wire

// File: hdl/ooo_alu_slice.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module ooo_alu_slice (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 dispatch_valid,
	input  logic [`TAG_W-1:0]    dispatch_tag,
	input  ooo_pkg::alu_func_e   dispatch_func,
	input  ooo_pkg::opa_select_e dispatch_opa_sel,
	input  ooo_pkg::opb_select_e dispatch_opb_sel,
	input  logic [`XLEN-1:0]     dispatch_pc,
	input  logic [`INST_W-1:0]   dispatch_inst,
	input  logic [`XLEN-1:0]     src1_value,
	input  logic                 src1_ready,
	input  logic [`TAG_W-1:0]    src1_tag,
	input  logic [`XLEN-1:0]     src2_value,
	input  logic                 src2_ready,
	input  logic [`TAG_W-1:0]    src2_tag,
	output logic                 dispatch_ready,
	output logic                 cdb_valid,
	output logic [`TAG_W-1:0]    cdb_tag,
	output logic [`XLEN-1:0]     cdb_value
);
	import ooo_pkg::*;

	logic               issue_valid;
	logic [`TAG_W-1:0]  issue_tag;
	alu_func_e          issue_func;
	opa_select_e        issue_opa_sel;
	opb_select_e        issue_opb_sel;
	logic [`XLEN-1:0]   issue_pc;
	logic [`INST_W-1:0] issue_inst;
	logic [`XLEN-1:0]   issue_rs1_value;
	logic [`XLEN-1:0]   issue_rs2_value;
	logic               fu_busy;
	logic               fu_result_valid;
	logic [`TAG_W-1:0]  fu_tag;
	logic [`XLEN-1:0]   fu_result;

	// the bus loops back into the station for wakeup
	reservation_station i_station (
		.clock            (clock),
		.reset            (reset),
		.flush            (flush),
		.dispatch_valid   (dispatch_valid),
		.dispatch_tag     (dispatch_tag),
		.dispatch_func    (dispatch_func),
		.dispatch_opa_sel (dispatch_opa_sel),
		.dispatch_opb_sel (dispatch_opb_sel),
		.dispatch_pc      (dispatch_pc),
		.dispatch_inst    (dispatch_inst),
		.src1_value       (src1_value),
		.src1_ready       (src1_ready),
		.src1_tag         (src1_tag),
		.src2_value       (src2_value),
		.src2_ready       (src2_ready),
		.src2_tag         (src2_tag),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_value        (cdb_value),
		.fu_busy          (fu_busy),
		.dispatch_ready   (dispatch_ready),
		.issue_valid      (issue_valid),
		.issue_tag        (issue_tag),
		.issue_func       (issue_func),
		.issue_opa_sel    (issue_opa_sel),
		.issue_opb_sel    (issue_opb_sel),
		.issue_pc         (issue_pc),
		.issue_inst       (issue_inst),
		.issue_rs1_value  (issue_rs1_value),
		.issue_rs2_value  (issue_rs2_value)
	);

	alu_fu i_alu_fu (
		.clock           (clock),
		.reset           (reset),
		.flush           (flush),
		.issue_valid     (issue_valid),
		.issue_tag       (issue_tag),
		.issue_func      (issue_func),
		.issue_opa_sel   (issue_opa_sel),
		.issue_opb_sel   (issue_opb_sel),
		.issue_pc        (issue_pc),
		.issue_inst      (issue_inst),
		.issue_rs1_value (issue_rs1_value),
		.issue_rs2_value (issue_rs2_value),
		.fu_busy         (fu_busy),
		.fu_result_valid (fu_result_valid),
		.fu_tag          (fu_tag),
		.fu_result       (fu_result)
	);

	result_broadcast i_broadcast (
		.clock           (clock),
		.reset           (reset),
		.flush           (flush),
		.fu_result_valid (fu_result_valid),
		.fu_tag          (fu_tag),
		.fu_result       (fu_result),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.cdb_value       (cdb_value)
	);

endmodule

`default_nettype wire

// File: hdl/result_broadcast.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module result_broadcast (
	input  logic              clock,
	input  logic              reset,
	input  logic              flush,
	input  logic              fu_result_valid,
	input  logic [`TAG_W-1:0] fu_tag,
	input  logic [`XLEN-1:0]  fu_result,
	output logic              cdb_valid,
	output logic [`TAG_W-1:0] cdb_tag,
	output logic [`XLEN-1:0]  cdb_value
);

	// one register stage keeps the ALU path away from the wakeup compare
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= fu_result_valid;
		end
	end

	// tag and value hold until the next result
	always_ff @(posedge clock) begin
		if (fu_result_valid) begin
			cdb_tag   <= fu_tag;
			cdb_value <= fu_result;
		end
	end

endmodule

`default_nettype wire

// File: hdl/alu_fu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module alu_fu (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 issue_valid,
	input  logic [`TAG_W-1:0]    issue_tag,
	input  ooo_pkg::alu_func_e   issue_func,
	input  ooo_pkg::opa_select_e issue_opa_sel,
	input  ooo_pkg::opb_select_e issue_opb_sel,
	input  logic [`XLEN-1:0]     issue_pc,
	input  logic [`INST_W-1:0]   issue_inst,
	input  logic [`XLEN-1:0]     issue_rs1_value,
	input  logic [`XLEN-1:0]     issue_rs2_value,
	output logic                 fu_busy,
	output logic                 fu_result_valid,
	output logic [`TAG_W-1:0]    fu_tag,
	output logic [`XLEN-1:0]     fu_result
);
	import ooo_pkg::*;

	// fillers that show up on a bad operand select
	localparam logic [`XLEN-1:0] OPA_FILLER = `XLEN'hdead_0a0a;
	localparam logic [`XLEN-1:0] OPB_FILLER = `XLEN'hdead_0b0b;

	logic               work_valid;
	logic [`TAG_W-1:0]  work_tag;
	alu_func_e          work_func;
	opa_select_e        work_opa_sel;
	opb_select_e        work_opb_sel;
	logic [`XLEN-1:0]   work_pc;
	logic [`INST_W-1:0] work_inst;
	logic [`XLEN-1:0]   work_rs1;
	logic [`XLEN-1:0]   work_rs2;

	logic [`XLEN-1:0] i_imm;
	logic [`XLEN-1:0] u_imm;
	logic [`XLEN-1:0] opa_mux;
	logic [`XLEN-1:0] opb_mux;

	// instruction sits here for the one cycle the ALU samples it
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			work_valid <= 1'b0;
		end else begin
			work_valid <= issue_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid) begin
			work_tag     <= issue_tag;
			work_func    <= issue_func;
			work_opa_sel <= issue_opa_sel;
			work_opb_sel <= issue_opb_sel;
			work_pc      <= issue_pc;
			work_inst    <= issue_inst;
			work_rs1     <= issue_rs1_value;
			work_rs2     <= issue_rs2_value;
		end
	end

	// sign extended I and U immediates
	assign i_imm = {{(`XLEN - 12){work_inst[31]}}, work_inst[31:20]};
	assign u_imm = {{(`XLEN - 20){work_inst[31]}}, work_inst[31:12]} << 12;

	always_comb begin
		case (work_opa_sel)
			OPA_IS_RS1:  opa_mux = work_rs1;
			OPA_IS_PC:   opa_mux = work_pc;
			OPA_IS_ZERO: opa_mux = '0;
			default:     opa_mux = OPA_FILLER;
		endcase
	end

	always_comb begin
		case (work_opb_sel)
			OPB_IS_RS2:   opb_mux = work_rs2;
			OPB_IS_I_IMM: opb_mux = i_imm;
			OPB_IS_U_IMM: opb_mux = u_imm;
			default:      opb_mux = OPB_FILLER;
		endcase
	end

	// a new issue or a flush discards anything still in the ALU
	alu i_alu (
		.clock   (clock),
		.reset   (reset),
		.refresh (flush || issue_valid),
		.start   (work_valid),
		.opa     (opa_mux),
		.opb     (opb_mux),
		.func    (work_func),
		.valid   (fu_result_valid),
		.result  (fu_result)
	);

	assign fu_busy = work_valid;
	assign fu_tag  = work_tag;

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module alu (
	input  logic               clock,
	input  logic               reset,
	input  logic               refresh,
	input  logic               start,
	input  logic [`XLEN-1:0]   opa,
	input  logic [`XLEN-1:0]   opb,
	input  ooo_pkg::alu_func_e func,
	output logic               valid,
	output logic [`XLEN-1:0]   result
);
	import ooo_pkg::*;

	logic [`XLEN-1:0] result_next;
	logic [4:0]       shamt;

	// shifts only look at the low five bits
	assign shamt = opb[4:0];

	always_comb begin
		case (func)
			ADD:     result_next = opa + opb;
			SUB:     result_next = opa - opb;
			SLT:     result_next = `XLEN'($signed(opa) < $signed(opb));
			SLTU:    result_next = `XLEN'(opa < opb);
			AND:     result_next = opa & opb;
			OR:      result_next = opa | opb;
			XOR:     result_next = opa ^ opb;
			SLL:     result_next = opa << shamt;
			SRL:     result_next = opa >> shamt;
			SRA:     result_next = $signed(opa) >>> shamt;
			default: result_next = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset || refresh) begin
			valid <= 1'b0;
		end else begin
			valid <= start;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			result <= result_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module reservation_station (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 dispatch_valid,
	input  logic [`TAG_W-1:0]    dispatch_tag,
	input  ooo_pkg::alu_func_e   dispatch_func,
	input  ooo_pkg::opa_select_e dispatch_opa_sel,
	input  ooo_pkg::opb_select_e dispatch_opb_sel,
	input  logic [`XLEN-1:0]     dispatch_pc,
	input  logic [`INST_W-1:0]   dispatch_inst,
	input  logic [`XLEN-1:0]     src1_value,
	input  logic                 src1_ready,
	input  logic [`TAG_W-1:0]    src1_tag,
	input  logic [`XLEN-1:0]     src2_value,
	input  logic                 src2_ready,
	input  logic [`TAG_W-1:0]    src2_tag,
	input  logic                 cdb_valid,
	input  logic [`TAG_W-1:0]    cdb_tag,
	input  logic [`XLEN-1:0]     cdb_value,
	input  logic                 fu_busy,
	output logic                 dispatch_ready,
	output logic                 issue_valid,
	output logic [`TAG_W-1:0]    issue_tag,
	output ooo_pkg::alu_func_e   issue_func,
	output ooo_pkg::opa_select_e issue_opa_sel,
	output ooo_pkg::opb_select_e issue_opb_sel,
	output logic [`XLEN-1:0]     issue_pc,
	output logic [`INST_W-1:0]   issue_inst,
	output logic [`XLEN-1:0]     issue_rs1_value,
	output logic [`XLEN-1:0]     issue_rs2_value
);
	import ooo_pkg::*;

	// entry index and age share one width
	localparam int IDX_W = $clog2(`RS_DEPTH);

	logic [`RS_DEPTH-1:0] valid_q;
	logic [`RS_DEPTH-1:0] armed_q;
	logic [`RS_DEPTH-1:0] rdy1_q;
	logic [`RS_DEPTH-1:0] rdy2_q;
	logic [IDX_W-1:0]     age_q      [`RS_DEPTH];
	logic [`TAG_W-1:0]    tag_q      [`RS_DEPTH];
	logic [`TAG_W-1:0]    src1_tag_q [`RS_DEPTH];
	logic [`TAG_W-1:0]    src2_tag_q [`RS_DEPTH];
	logic [`XLEN-1:0]     val1_q     [`RS_DEPTH];
	logic [`XLEN-1:0]     val2_q     [`RS_DEPTH];
	alu_func_e            func_q     [`RS_DEPTH];
	opa_select_e          opa_q      [`RS_DEPTH];
	opb_select_e          opb_q      [`RS_DEPTH];
	logic [`XLEN-1:0]     pc_q       [`RS_DEPTH];
	logic [`INST_W-1:0]   inst_q     [`RS_DEPTH];

	logic             free_found;
	logic [IDX_W-1:0] free_idx;
	logic             pick_found;
	logic [IDX_W-1:0] pick_idx;
	logic [IDX_W-1:0] pick_age;
	logic [IDX_W:0]   occupancy;
	logic [IDX_W-1:0] new_age;
	logic             do_dispatch;
	logic             src1_hit;
	logic             src2_hit;

	// lowest free slot, oldest armed entry, live entry count
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		pick_found = 1'b0;
		pick_idx   = '0;
		pick_age   = '1;
		occupancy  = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				free_found = 1'b1;
				free_idx   = IDX_W'(i);
			end
		end
		for (int i = 0; i < `RS_DEPTH; i++) begin
			occupancy = occupancy + (IDX_W + 1)'(valid_q[i]);
			if (armed_q[i] && (!pick_found || age_q[i] < pick_age)) begin
				pick_found = 1'b1;
				pick_idx   = IDX_W'(i);
				pick_age   = age_q[i];
			end
		end
	end

	assign dispatch_ready = free_found;
	assign do_dispatch    = dispatch_valid && free_found;
	assign issue_valid    = pick_found && !fu_busy;

	// a new entry lines up behind every entry that stays
	assign new_age = IDX_W'(occupancy - (IDX_W + 1)'(issue_valid));

	// operand arriving on the bus in the dispatch cycle
	assign src1_hit = cdb_valid && (src1_tag == cdb_tag);
	assign src2_hit = cdb_valid && (src2_tag == cdb_tag);

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			valid_q <= '0;
			armed_q <= '0;
		end else begin
			for (int i = 0; i < `RS_DEPTH; i++) begin
				// eligible one cycle after both operands are held
				armed_q[i] <= valid_q[i] && rdy1_q[i] && rdy2_q[i];
				if (issue_valid && pick_idx == IDX_W'(i)) begin
					valid_q[i] <= 1'b0;
					armed_q[i] <= 1'b0;
				end
				if (do_dispatch && free_idx == IDX_W'(i)) begin
					valid_q[i] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			// younger entries move up when one leaves
			if (issue_valid && valid_q[i] && age_q[i] > pick_age) begin
				age_q[i] <= age_q[i] - 1'b1;
			end
			// wakeup from the common data bus
			if (valid_q[i] && cdb_valid && !rdy1_q[i] && src1_tag_q[i] == cdb_tag) begin
				rdy1_q[i] <= 1'b1;
				val1_q[i] <= cdb_value;
			end
			if (valid_q[i] && cdb_valid && !rdy2_q[i] && src2_tag_q[i] == cdb_tag) begin
				rdy2_q[i] <= 1'b1;
				val2_q[i] <= cdb_value;
			end
			if (do_dispatch && free_idx == IDX_W'(i)) begin
				age_q[i]      <= new_age;
				tag_q[i]      <= dispatch_tag;
				func_q[i]     <= dispatch_func;
				opa_q[i]      <= dispatch_opa_sel;
				opb_q[i]      <= dispatch_opb_sel;
				pc_q[i]       <= dispatch_pc;
				inst_q[i]     <= dispatch_inst;
				src1_tag_q[i] <= src1_tag;
				src2_tag_q[i] <= src2_tag;
				rdy1_q[i]     <= src1_ready || src1_hit;
				rdy2_q[i]     <= src2_ready || src2_hit;
				val1_q[i]     <= src1_ready ? src1_value : cdb_value;
				val2_q[i]     <= src2_ready ? src2_value : cdb_value;
			end
		end
	end

	// issue fields straight from the picked entry
	assign issue_tag       = tag_q[pick_idx];
	assign issue_func      = func_q[pick_idx];
	assign issue_opa_sel   = opa_q[pick_idx];
	assign issue_opb_sel   = opb_q[pick_idx];
	assign issue_pc        = pc_q[pick_idx];
	assign issue_inst      = inst_q[pick_idx];
	assign issue_rs1_value = val1_q[pick_idx];
	assign issue_rs2_value = val2_q[pick_idx];

endmodule

`default_nettype wire

// File: hdl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

	// integer ALU operations, RV32I semantics
	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		SLT  = 4'h2,
		SLTU = 4'h3,
		AND  = 4'h4,
		OR   = 4'h5,
		XOR  = 4'h6,
		SLL  = 4'h7,
		SRL  = 4'h8,
		SRA  = 4'h9
	} alu_func_e;

	// operand A source
	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_PC   = 2'h1,
		OPA_IS_ZERO = 2'h2
	} opa_select_e;

	// operand B source
	// immediates come from the instruction word
	typedef enum logic [1:0] {
		OPB_IS_RS2   = 2'h0,
		OPB_IS_I_IMM = 2'h1,
		OPB_IS_U_IMM = 2'h2
	} opb_select_e;

endpackage

`default_nettype wire

// File: hdl/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// data path width
`define XLEN 32

// instruction word width
`define INST_W 32

// producer tag width
// sixteen tags in flight at most
`define TAG_W 4

// reservation station entries
// the station also works with 2 or 8
`define RS_DEPTH 4

`endif
